// File: alu_issue.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/rs_pkg.sv
verilog/rs_alu.sv
verilog/phys_regfile.sv
verilog/alu_exec.sv
verilog/alu_issue_top.sv
testbench/tb_alu_issue.sv

// File: testbench/alu_issue_cases.txt
# T name | W tag data | D op src1 rdy1 src2 rdy2 dst imm use_imm expected latency | R ready
# N tag cycles (no result yet) | F flush | E end of test; tags and flags decimal, data hex
T ready_operands
W 1 00000005
W 2 00000007
D ADD 1 1 2 1 10 00000000 0 0000000c 2
E
T every_opcode
W 3 fffffff0
D SUB 1 1 2 1 11 00000000 0 fffffffe 0
D AND 3 1 0 0 12 000000ff 1 000000f0 0
D OR 1 1 2 1 13 00000000 0 00000007 0
D XOR 1 1 0 0 14 0000000f 1 0000000a 0
D SLL 1 1 0 0 15 00000024 1 00000050 0
D SRL 3 1 2 1 16 00000000 0 01ffffff 0
D SLT 3 1 1 1 17 00000000 0 00000001 0
D SLT 1 1 3 1 18 00000000 0 00000000 0
E
T external_wakeup
D ADD 20 0 1 1 21 00000000 0 00000105 0
N 21 10
W 20 00000100
E
T chained_dependency
D SUB 2 1 1 1 22 00000000 0 00000002 0
D SLL 1 1 22 0 23 00000000 0 00000014 0
E
T back_pressure
D ADD 40 0 0 0 41 00000001 1 00000201 0
D ADD 40 0 0 0 42 00000002 1 00000202 0
D OR 40 0 0 0 43 0000000f 1 0000020f 0
D ADD 40 0 0 0 44 00000004 1 00000204 0
D ADD 40 0 0 0 45 00000005 1 00000205 0
D SRL 40 0 0 0 46 00000004 1 00000020 0
D ADD 40 0 0 0 47 00000007 1 00000207 0
D ADD 40 0 0 0 48 00000008 1 00000208 0
R 0
W 40 00000200
D ADD 40 1 0 0 49 00000009 1 00000209 0
E
T flush
D OR 50 0 1 1 51 00000000 0 00000000 0
D AND 50 0 2 1 52 00000000 0 00000000 0
F
W 50 00000033
N 51 10
N 52 10
D XOR 50 1 2 1 53 00000000 0 00000034 0
E

// File: testbench/tb_alu_issue.sv
`timescale 1ns/1ps

module tb_alu_issue;
  import alu_pkg::*;
  import rs_pkg::*;

  localparam int WAIT_LIMIT = 200;
  localparam int NUM_TAGS   = 2 ** $bits(phys_tag_t);

  logic      clk;
  logic      rst_n;
  logic      flush;
  logic      dispatch_valid;
  alu_op_e   dispatch_op;
  phys_tag_t dispatch_src1_tag;
  logic      dispatch_src1_ready;
  phys_tag_t dispatch_src2_tag;
  logic      dispatch_src2_ready;
  phys_tag_t dispatch_dst_tag;
  xlen_t     dispatch_imm;
  logic      dispatch_use_imm;
  logic      dispatch_ready;
  logic      ext_wb_valid;
  phys_tag_t ext_wb_tag;
  xlen_t     ext_wb_data;
  logic      alu_wb_valid;
  phys_tag_t alu_wb_tag;
  xlen_t     alu_wb_data;

  // Scoreboard indexed by destination tag
  logic  seen      [NUM_TAGS];
  xlen_t seen_data [NUM_TAGS];
  int    seen_edge [NUM_TAGS];
  logic  pending   [NUM_TAGS];
  xlen_t exp_data  [NUM_TAGS];
  int    exp_lat   [NUM_TAGS];
  int    acc_edge  [NUM_TAGS];

  int edge_count   = 0;
  int test_errors  = 0;
  int total_errors = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int checks       = 0;
  bit aborted      = 1'b0;

  alu_issue_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) edge_count <= edge_count + 1;

  // ####################
  // Broadcast monitor, sampled mid-cycle

  always @(negedge clk) begin
    if (rst_n && alu_wb_valid) begin
      checks++;
      assert (pending[alu_wb_tag]) else begin
        $display("[FAIL] %0t ns: unexpected broadcast on tag %0d", $time, alu_wb_tag);
        test_errors++;
      end
      seen[alu_wb_tag]      = 1'b1;
      seen_data[alu_wb_tag] = alu_wb_data;
      seen_edge[alu_wb_tag] = edge_count;
    end
  end

  function automatic bit decode_op(input logic [63:0] name, output alu_op_e op);
    decode_op = 1'b1;
    case (name)
      "ADD": op = ADD;
      "SUB": op = SUB;
      "AND": op = AND;
      "OR":  op = OR;
      "XOR": op = XOR;
      "SLL": op = SLL;
      "SRL": op = SRL;
      "SLT": op = SLT;
      default: begin
        op        = ADD;
        decode_op = 1'b0;
      end
    endcase
  endfunction

  task automatic next_cycle;
    @(posedge clk);
    #2;
    ext_wb_valid = 1'b0;  // An external write holds for a single cycle
  endtask

  task automatic write_ext(input int tag, input xlen_t data);
    if (ext_wb_valid) begin
      next_cycle();  // One external write per cycle
    end
    ext_wb_valid = 1'b1;
    ext_wb_tag   = phys_tag_t'(tag);
    ext_wb_data  = data;
  endtask

  task automatic send_dispatch(input alu_op_e op, input int src1, input int rdy1,
                               input int src2, input int rdy2, input int dst,
                               input xlen_t imm, input int use_imm, input xlen_t expv,
                               input int lat);
    int waited;
    bit accepted;
    waited              = 0;
    accepted            = 1'b0;
    dispatch_valid      = 1'b1;
    dispatch_op         = op;
    dispatch_src1_tag   = phys_tag_t'(src1);
    dispatch_src1_ready = rdy1[0];
    dispatch_src2_tag   = phys_tag_t'(src2);
    dispatch_src2_ready = rdy2[0];
    dispatch_dst_tag    = phys_tag_t'(dst);
    dispatch_imm        = imm;
    dispatch_use_imm    = use_imm[0];
    while (!accepted && waited < WAIT_LIMIT) begin
      @(negedge clk);
      accepted = dispatch_ready;  // Held here while the station is full
      next_cycle();
      waited++;
    end
    dispatch_valid = 1'b0;
    if (accepted) begin
      seen[dst]     = 1'b0;
      pending[dst]  = 1'b1;
      exp_data[dst] = expv;
      exp_lat[dst]  = lat;
      acc_edge[dst] = edge_count;
    end else begin
      $display("Timed out waiting for the station to accept the dispatch to tag %0d", dst);
      aborted = 1'b1;
    end
  endtask

  task automatic flush_station;
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      pending[t] = 1'b0;
    end
  endtask

  task automatic expect_silent(input int tag, input int cycles);
    repeat (cycles) next_cycle();
    checks++;
    assert (!seen[tag]) else begin
      $display("[FAIL] %0t ns: tag %0d was broadcast too early", $time, tag);
      test_errors++;
    end
  endtask

  task automatic check_ready(input int value);
    checks++;
    assert (dispatch_ready == value[0]) else begin
      $display("[FAIL] %0t ns: dispatch_ready is %0b, expected %0b", $time, dispatch_ready,
               value[0]);
      test_errors++;
    end
  endtask

  task automatic finish_test(input logic [8*32-1:0] name);
    int waited;
    if (ext_wb_valid) begin
      next_cycle();
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (pending[t] && !aborted) begin
        waited = 0;
        while (!seen[t] && waited < WAIT_LIMIT) begin
          next_cycle();
          waited++;
        end
        if (!seen[t]) begin
          $display("Timed out waiting for a result on tag %0d", t);
          aborted = 1'b1;
        end else begin
          checks++;
          assert (seen_data[t] == exp_data[t]) else begin
            $display("[FAIL] %0t ns: tag %0d gave %h, expected %h", $time, t, seen_data[t],
                     exp_data[t]);
            test_errors++;
          end
          if (exp_lat[t] != 0) begin
            checks++;
            assert (seen_edge[t] - acc_edge[t] == exp_lat[t]) else begin
              $display("[FAIL] %0t ns: tag %0d took %0d edges, expected %0d", $time, t,
                       seen_edge[t] - acc_edge[t], exp_lat[t]);
              test_errors++;
            end
          end
        end
        pending[t] = 1'b0;
      end
    end
    tests_run++;
    if (aborted) begin
      $display("test %0s: stopped by a timeout", name);
      tests_failed++;
    end else if (test_errors != 0) begin
      $display("test %0s: %0d errors", name, test_errors);
      tests_failed++;
    end else begin
      $display("test %0s: ok", name);
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // ####################
  // Cases file replay

  initial begin
    int               fd;
    int               n;
    int               src1;
    int               rdy1;
    int               src2;
    int               rdy2;
    int               dst;
    int               use_imm;
    int               lat;
    xlen_t            imm;
    xlen_t            expv;
    alu_op_e          op;
    logic [7:0]       cmd;
    logic [63:0]      opname;
    logic [8*32-1:0]  name;
    logic [8*128-1:0] line;
    void'($urandom(32'h8232));
    for (int t = 0; t < NUM_TAGS; t++) begin
      seen[t]    = 1'b0;
      pending[t] = 1'b0;
    end
    name                = "unnamed";
    flush               = 1'b0;
    dispatch_valid      = 1'b0;
    dispatch_op         = ADD;
    dispatch_src1_tag   = '0;
    dispatch_src1_ready = 1'b0;
    dispatch_src2_tag   = '0;
    dispatch_src2_ready = 1'b0;
    dispatch_dst_tag    = '0;
    dispatch_imm        = '0;
    dispatch_use_imm    = 1'b0;
    ext_wb_valid        = 1'b0;
    ext_wb_tag          = '0;
    ext_wb_data         = '0;
    rst_n               = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fd = $fopen("testbench/alu_issue_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/alu_issue_cases.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && !$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, " %c", cmd) == 1) begin
          case (cmd)
            "#": ;
            "T": begin
              name = '0;
              n = $sscanf(line, " %c %s", cmd, name);
            end
            "W": begin
              n = $sscanf(line, " %c %d %h", cmd, dst, expv);
              write_ext(dst, expv);
            end
            "D": begin
              n = $sscanf(line, " %c %s %d %d %d %d %d %h %d %h %d", cmd, opname, src1, rdy1,
                          src2, rdy2, dst, imm, use_imm, expv, lat);
              if (n != 11 || !decode_op(opname, op)) begin
                $display("Malformed dispatch line in the cases file");
                aborted = 1'b1;
              end else begin
                send_dispatch(op, src1, rdy1, src2, rdy2, dst, imm, use_imm, expv, lat);
              end
            end
            "F": flush_station();
            "N": begin
              n = $sscanf(line, " %c %d %d", cmd, dst, lat);
              expect_silent(dst, lat);
            end
            "R": begin
              n = $sscanf(line, " %c %d", cmd, rdy1);
              check_ready(rdy1);
            end
            "E": finish_test(name);
            default: begin
              $display("Unknown command in the cases file");
              aborted = 1'b1;
            end
          endcase
        end
      end
      $fclose(fd);
    end
    total_errors += test_errors;
    $display("%0d tests run, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             checks, total_errors);
    if (total_errors == 0 && !aborted && tests_run > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue_valid,
  input  alu_pkg::alu_op_e  issue_op,
  input  rs_pkg::phys_tag_t issue_dst_tag,
  input  alu_pkg::xlen_t    issue_imm,
  input  logic              issue_use_imm,
  input  alu_pkg::xlen_t    rd1_data,
  input  alu_pkg::xlen_t    rd2_data,
  output logic              alu_wb_valid,
  output rs_pkg::phys_tag_t alu_wb_tag,
  output alu_pkg::xlen_t    alu_wb_data
);
  import alu_pkg::*;

  xlen_t      op_b;
  xlen_t      result;
  logic [4:0] shamt;

  assign op_b  = issue_use_imm ? issue_imm : rd2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (issue_op)
      ADD:     result = rd1_data + op_b;
      SUB:     result = rd1_data - op_b;
      AND:     result = rd1_data & op_b;
      OR:      result = rd1_data | op_b;
      XOR:     result = rd1_data ^ op_b;
      SLL:     result = rd1_data << shamt;
      SRL:     result = rd1_data >> shamt;
      SLT:     result = xlen_t'($signed(rd1_data) < $signed(op_b));
      default: result = '0;  // Unused encodings
    endcase
  end

  // ####################
  // Result broadcast

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_wb_valid <= 1'b0;
    end else begin
      alu_wb_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      alu_wb_tag  <= issue_dst_tag;
      alu_wb_data <= result;
    end
  end

endmodule

// File: verilog/alu_issue_config.svh
`ifndef ALU_ISSUE_CONFIG_SVH
`define ALU_ISSUE_CONFIG_SVH

// Reservation station entries
`define RS_DEPTH 8

// Physical register tag width, 64 registers
`define PHYS_TAG_W 6

// Integer data width
`define XLEN 32

`endif

// File: verilog/alu_issue_top.sv
`timescale 1ns/1ps

module alu_issue_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              dispatch_valid,
  input  alu_pkg::alu_op_e  dispatch_op,
  input  rs_pkg::phys_tag_t dispatch_src1_tag,
  input  logic              dispatch_src1_ready,
  input  rs_pkg::phys_tag_t dispatch_src2_tag,
  input  logic              dispatch_src2_ready,
  input  rs_pkg::phys_tag_t dispatch_dst_tag,
  input  alu_pkg::xlen_t    dispatch_imm,
  input  logic              dispatch_use_imm,
  output logic              dispatch_ready,
  input  logic              ext_wb_valid,
  input  rs_pkg::phys_tag_t ext_wb_tag,
  input  alu_pkg::xlen_t    ext_wb_data,
  output logic              alu_wb_valid,
  output rs_pkg::phys_tag_t alu_wb_tag,
  output alu_pkg::xlen_t    alu_wb_data
);
  import rs_pkg::*;
  import alu_pkg::*;

  logic      issue_valid;
  alu_op_e   issue_op;
  phys_tag_t issue_src1_tag;
  phys_tag_t issue_src2_tag;
  phys_tag_t issue_dst_tag;
  xlen_t     issue_imm;
  logic      issue_use_imm;
  xlen_t     rd1_data;
  xlen_t     rd2_data;

  rs_alu rs_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .flush               (flush),
    .dispatch_valid      (dispatch_valid),
    .dispatch_op         (dispatch_op),
    .dispatch_src1_tag   (dispatch_src1_tag),
    .dispatch_src1_ready (dispatch_src1_ready),
    .dispatch_src2_tag   (dispatch_src2_tag),
    .dispatch_src2_ready (dispatch_src2_ready),
    .dispatch_dst_tag    (dispatch_dst_tag),
    .dispatch_imm        (dispatch_imm),
    .dispatch_use_imm    (dispatch_use_imm),
    .dispatch_ready      (dispatch_ready),
    .ext_wb_valid        (ext_wb_valid),
    .ext_wb_tag          (ext_wb_tag),
    .alu_wb_valid        (alu_wb_valid),  // Own result loops back for wakeup
    .alu_wb_tag          (alu_wb_tag),
    .issue_valid         (issue_valid),
    .issue_op            (issue_op),
    .issue_src1_tag      (issue_src1_tag),
    .issue_src2_tag      (issue_src2_tag),
    .issue_dst_tag       (issue_dst_tag),
    .issue_imm           (issue_imm),
    .issue_use_imm       (issue_use_imm)
  );

  // Port 0 takes the external broadcast and port 1 the ALU result
  phys_regfile rf_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .we0    (ext_wb_valid),
    .waddr0 (ext_wb_tag),
    .wdata0 (ext_wb_data),
    .we1    (alu_wb_valid),
    .waddr1 (alu_wb_tag),
    .wdata1 (alu_wb_data),
    .raddr1 (issue_src1_tag),
    .raddr2 (issue_src2_tag),
    .rdata1 (rd1_data),
    .rdata2 (rd2_data)
  );

  alu_exec alu_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_dst_tag (issue_dst_tag),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .rd1_data      (rd1_data),
    .rd2_data      (rd2_data),
    .alu_wb_valid  (alu_wb_valid),
    .alu_wb_tag    (alu_wb_tag),
    .alu_wb_data   (alu_wb_data)
  );

endmodule

// File: verilog/alu_pkg.sv
`include "alu_issue_config.svh"

package alu_pkg;

  // ALU operations carried from dispatch through to execute
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    SLT = 4'd7  // Signed compare, result is 0 or 1
  } alu_op_e;

  typedef logic [`XLEN-1:0] xlen_t;

endpackage

// File: verilog/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we0,
  input  rs_pkg::phys_tag_t waddr0,
  input  alu_pkg::xlen_t    wdata0,
  input  logic              we1,
  input  rs_pkg::phys_tag_t waddr1,
  input  alu_pkg::xlen_t    wdata1,
  input  rs_pkg::phys_tag_t raddr1,
  input  rs_pkg::phys_tag_t raddr2,
  output alu_pkg::xlen_t    rdata1,
  output alu_pkg::xlen_t    rdata2
);
  import rs_pkg::*;
  import alu_pkg::*;

  localparam int NUM_REGS = 2 ** $bits(phys_tag_t);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0) begin
        regs[waddr0] <= wdata0;
      end
      if (we1) begin
        regs[waddr1] <= wdata1;  // Later assignment, so the ALU port wins
      end
    end
  end

  // Write-first bypass with the same port priority as the array
  always_comb begin
    rdata1 = regs[raddr1];
    if (we0 && waddr0 == raddr1) rdata1 = wdata0;
    if (we1 && waddr1 == raddr1) rdata1 = wdata1;
    rdata2 = regs[raddr2];
    if (we0 && waddr0 == raddr2) rdata2 = wdata0;
    if (we1 && waddr1 == raddr2) rdata2 = wdata1;
  end

  // Rename never hands one tag to two producers at once
  a_no_double_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(we0 && we1 && waddr0 == waddr1));

endmodule

// File: verilog/rs_alu.sv
`timescale 1ns/1ps
`include "alu_issue_config.svh"

module rs_alu #(
  parameter int DEPTH = `RS_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              dispatch_valid,
  input  alu_pkg::alu_op_e  dispatch_op,
  input  rs_pkg::phys_tag_t dispatch_src1_tag,
  input  logic              dispatch_src1_ready,
  input  rs_pkg::phys_tag_t dispatch_src2_tag,
  input  logic              dispatch_src2_ready,
  input  rs_pkg::phys_tag_t dispatch_dst_tag,
  input  alu_pkg::xlen_t    dispatch_imm,
  input  logic              dispatch_use_imm,
  output logic              dispatch_ready,
  input  logic              ext_wb_valid,
  input  rs_pkg::phys_tag_t ext_wb_tag,
  input  logic              alu_wb_valid,
  input  rs_pkg::phys_tag_t alu_wb_tag,
  output logic              issue_valid,
  output alu_pkg::alu_op_e  issue_op,
  output rs_pkg::phys_tag_t issue_src1_tag,
  output rs_pkg::phys_tag_t issue_src2_tag,
  output rs_pkg::phys_tag_t issue_dst_tag,
  output alu_pkg::xlen_t    issue_imm,
  output logic              issue_use_imm
);
  import rs_pkg::*;
  import alu_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_state_e entry_state   [DEPTH];
  logic         entry_rdy1    [DEPTH];
  logic         entry_rdy2    [DEPTH];
  alu_op_e      entry_op      [DEPTH];
  phys_tag_t    entry_src1    [DEPTH];
  phys_tag_t    entry_src2    [DEPTH];
  phys_tag_t    entry_dst     [DEPTH];
  xlen_t        entry_imm     [DEPTH];
  logic         entry_use_imm [DEPTH];

  logic [DEPTH-1:0] occupied;
  logic [DEPTH-1:0] src1_now;
  logic [DEPTH-1:0] src2_now;
  logic [DEPTH-1:0] can_issue;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             free_found;
  logic             sel_valid;
  logic             disp_rdy1;
  logic             disp_rdy2;
  logic             dispatch_fire;

  // True when either broadcast carries this tag in the current cycle
  function automatic logic tag_hit(phys_tag_t tag);
    return (ext_wb_valid && ext_wb_tag == tag) || (alu_wb_valid && alu_wb_tag == tag);
  endfunction

  // ####################
  // Wakeup and select

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      occupied[i]  = (entry_state[i] != ENTRY_FREE);
      src1_now[i]  = entry_rdy1[i] || tag_hit(entry_src1[i]);
      src2_now[i]  = entry_rdy2[i] || tag_hit(entry_src2[i]);
      // A waiting entry woken this cycle may already be picked
      can_issue[i] = (entry_state[i] == ENTRY_READY) ||
                     (entry_state[i] == ENTRY_WAITING && src1_now[i] && src2_now[i]);
    end
    disp_rdy1 = dispatch_src1_ready || tag_hit(dispatch_src1_tag);
    disp_rdy2 = dispatch_src2_ready || dispatch_use_imm || tag_hit(dispatch_src2_tag);
  end

  // Scan downwards so the lowest index wins both searches
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    sel_valid  = 1'b0;
    sel_idx    = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
      if (can_issue[i]) begin
        sel_valid = 1'b1;
        sel_idx   = IDX_W'(i);
      end
    end
  end

  assign dispatch_ready = free_found;
  assign dispatch_fire  = dispatch_valid && dispatch_ready && !flush;

  // ####################
  // Entry state

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        entry_state[i] <= ENTRY_FREE;
        entry_rdy1[i]  <= 1'b0;
        entry_rdy2[i]  <= 1'b0;
      end
    end else if (flush) begin
      for (int i = 0; i < DEPTH; i++) begin
        entry_state[i] <= ENTRY_FREE;
        entry_rdy1[i]  <= 1'b0;
        entry_rdy2[i]  <= 1'b0;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        entry_rdy1[i] <= src1_now[i];
        entry_rdy2[i] <= src2_now[i];
        if (occupied[i]) begin
          entry_state[i] <= (src1_now[i] && src2_now[i]) ? ENTRY_READY : ENTRY_WAITING;
        end
      end
      if (sel_valid) begin
        entry_state[sel_idx] <= ENTRY_FREE;
      end
      if (dispatch_fire) begin
        entry_state[free_idx] <= (disp_rdy1 && disp_rdy2) ? ENTRY_READY : ENTRY_WAITING;
        entry_rdy1[free_idx]  <= disp_rdy1;
        entry_rdy2[free_idx]  <= disp_rdy2;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch_fire) begin
      entry_op[free_idx]      <= dispatch_op;
      entry_src1[free_idx]    <= dispatch_src1_tag;
      entry_src2[free_idx]    <= dispatch_src2_tag;
      entry_dst[free_idx]     <= dispatch_dst_tag;
      entry_imm[free_idx]     <= dispatch_imm;
      entry_use_imm[free_idx] <= dispatch_use_imm;
    end
  end

  // ####################
  // Issue register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= sel_valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_valid) begin
      issue_op       <= entry_op[sel_idx];
      issue_src1_tag <= entry_src1[sel_idx];
      issue_src2_tag <= entry_src2[sel_idx];
      issue_dst_tag  <= entry_dst[sel_idx];
      issue_imm      <= entry_imm[sel_idx];
      issue_use_imm  <= entry_use_imm[sel_idx];
    end
  end

  // A refused dispatch takes no entry, so only an issue changes the count
  a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    (dispatch_valid && !dispatch_ready && !flush) |=>
      ($countones(occupied) == DEPTH - int'($past(sel_valid))));

  // Flush empties the station, so nothing issues for two cycles
  a_flush_kills_issue: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !issue_valid ##1 !issue_valid);

  // The issued entry held both operands and was released by the issue
  a_issue_from_live_entry: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |-> ($past(entry_state[sel_idx] != ENTRY_FREE && src1_now[sel_idx] &&
                           src2_now[sel_idx]) &&
                     entry_state[$past(sel_idx)] == ENTRY_FREE));

endmodule

// File: verilog/rs_pkg.sv
`include "alu_issue_config.svh"

package rs_pkg;

  // Physical register name as seen on every broadcast
  typedef logic [`PHYS_TAG_W-1:0] phys_tag_t;

  typedef enum logic [1:0] {
    ENTRY_FREE    = 2'd0,
    ENTRY_WAITING = 2'd1,  // At least one source still outstanding
    ENTRY_READY   = 2'd2
  } entry_state_e;

endpackage
